/* exu.f */
+incdir+src
src/exu_pkg.sv
src/exu_operand_fwd.sv
src/exu_alu.sv
src/exu_branch.sv
src/exu_mul.sv
src/exu_stage.sv
dv/exu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module exu_tb -f exu.f -o Vexu_tb \
    && ./obj_dir/Vexu_tb \
    || exit 1

/* dv/exu_tb.sv */
`include "exu_defs.svh"
`default_nettype none

module exu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MUL_TIMEOUT = 4 * `EXU_MUL_CYCLES;

    logic                  clk;
    logic                  rst_n;
    logic                  valid_id_ex;
    exu_pkg::id_ex_t       id_ex;
    exu_pkg::fwd_t         mem_fwd;
    exu_pkg::fwd_t         wb_fwd;
    logic                  ready_ex_mem;
    logic                  branch_flush;
    logic                  ready_id_ex;
    logic                  valid_ex_mem;
    exu_pkg::ex_mem_t      ex_mem;
    exu_pkg::xlen_t        dnpc;
    logic                  pc_update;

    exu_pkg::exu_op_e alu_ops [10] = '{exu_pkg::OP_ADD, exu_pkg::OP_SUB, exu_pkg::OP_SLL,
        exu_pkg::OP_SLT, exu_pkg::OP_SLTU, exu_pkg::OP_XOR, exu_pkg::OP_SRL,
        exu_pkg::OP_SRA, exu_pkg::OP_OR, exu_pkg::OP_AND};
    exu_pkg::exu_op_e br_ops [8] = '{exu_pkg::OP_BEQ, exu_pkg::OP_BNE, exu_pkg::OP_BLT,
        exu_pkg::OP_BGE, exu_pkg::OP_BLTU, exu_pkg::OP_BGEU, exu_pkg::OP_JAL,
        exu_pkg::OP_JALR};

    exu_stage UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_id_ex  (valid_id_ex),
        .id_ex        (id_ex),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .ready_ex_mem (ready_ex_mem),
        .branch_flush (branch_flush),
        .ready_id_ex  (ready_id_ex),
        .valid_ex_mem (valid_ex_mem),
        .ex_mem       (ex_mem),
        .dnpc         (dnpc),
        .pc_update    (pc_update)
    );

    always #4 clk = ~clk;  // 8 ns period

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_now(input string what);
        $display("ERROR: %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic exu_pkg::xlen_t rand_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic exu_pkg::id_ex_t make_pkt(input exu_pkg::exu_op_e op, input logic imm_form);
        exu_pkg::id_ex_t p;
        p.op      = op;
        p.use_imm = imm_form;
        p.pc      = rand_word() & ~64'h3;  // word aligned
        p.rd      = exu_pkg::reg_addr_t'($urandom());
        p.rs1     = exu_pkg::reg_addr_t'($urandom());
        p.rs2     = exu_pkg::reg_addr_t'($urandom());
        p.src_a   = rand_word();
        p.src_b   = rand_word();
        p.imm     = rand_word();
        return p;
    endfunction

    function automatic exu_pkg::fwd_t make_fwd(input logic wen, input exu_pkg::reg_addr_t rd);
        exu_pkg::fwd_t f;
        f.wen  = wen;
        f.rd   = rd;
        f.data = rand_word();
        return f;
    endfunction

    task automatic clear_fwd();
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    // wb applied before mem so that mem overrides it
    function automatic exu_pkg::xlen_t fwd_pick(input exu_pkg::reg_addr_t idx,
                                                input exu_pkg::xlen_t reg_val);
        exu_pkg::xlen_t v;
        v = reg_val;
        if ((idx != 0) && wb_fwd.wen && (wb_fwd.rd == idx)) begin
            v = wb_fwd.data;
        end
        if ((idx != 0) && mem_fwd.wen && (mem_fwd.rd == idx)) begin
            v = mem_fwd.data;
        end
        return v;
    endfunction

    function automatic exu_pkg::xlen_t alu_model(input exu_pkg::exu_op_e op,
        input exu_pkg::xlen_t pc, input exu_pkg::xlen_t a, input exu_pkg::xlen_t b);
        case (op)
            exu_pkg::OP_ADD:  return a + b;
            exu_pkg::OP_SUB:  return a - b;
            exu_pkg::OP_SLL:  return a << b[5:0];
            exu_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            exu_pkg::OP_SLTU: return (a < b) ? 64'd1 : 64'd0;
            exu_pkg::OP_XOR:  return a ^ b;
            exu_pkg::OP_SRL:  return a >> b[5:0];
            exu_pkg::OP_SRA:  return 64'($signed(a) >>> b[5:0]);
            exu_pkg::OP_OR:   return a | b;
            exu_pkg::OP_AND:  return a & b;
            exu_pkg::OP_JAL, exu_pkg::OP_JALR: return pc + 64'(`EXU_PC_STEP);  // link
            exu_pkg::OP_MUL:  return a * b;  // low half
            default:          return '0;
        endcase
    endfunction

    function automatic logic taken_model(input exu_pkg::exu_op_e op,
                                         input exu_pkg::xlen_t a, input exu_pkg::xlen_t b);
        case (op)
            exu_pkg::OP_BEQ:  return a == b;
            exu_pkg::OP_BNE:  return a != b;
            exu_pkg::OP_BLT:  return $signed(a) < $signed(b);
            exu_pkg::OP_BGE:  return $signed(a) >= $signed(b);
            exu_pkg::OP_BLTU: return a < b;
            exu_pkg::OP_BGEU: return a >= b;
            exu_pkg::OP_JAL, exu_pkg::OP_JALR: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    // drive one packet and let it be captured
    task automatic issue(input exu_pkg::id_ex_t p);
        check_eq("ready_id_ex", ready_id_ex, 1'b1);
        id_ex       = p;
        valid_id_ex = 1'b1;
        step();
        valid_id_ex = 1'b0;
    endtask

    // compare the stage outputs with the model for the registered packet
    task automatic check_exec(input exu_pkg::id_ex_t p);
        exu_pkg::xlen_t a;
        exu_pkg::xlen_t b;
        exu_pkg::xlen_t target;
        exu_pkg::xlen_t exp_pc;
        logic           reads_b;
        logic           taken;
        logic           is_br;
        reads_b = !p.use_imm && (p.op != exu_pkg::OP_JAL) && (p.op != exu_pkg::OP_JALR);
        a       = fwd_pick(p.rs1, p.src_a);
        b       = reads_b ? fwd_pick(p.rs2, p.src_b) : p.src_b;
        taken   = taken_model(p.op, a, b);
        target  = (p.op == exu_pkg::OP_JALR) ? a + p.imm : p.pc + p.imm;
        exp_pc  = taken ? target : p.pc + 64'(`EXU_PC_STEP);
        is_br   = (p.op >= exu_pkg::OP_BEQ) && (p.op <= exu_pkg::OP_BGEU);
        check_eq("valid_ex_mem", valid_ex_mem, 1'b1);
        check_eq("ex_mem.op", ex_mem.op, p.op);
        check_eq("ex_mem.rd", ex_mem.rd, p.rd);
        check_eq("ex_mem.pc", ex_mem.pc, p.pc);
        check_eq("ex_mem.store_data", ex_mem.store_data, b);
        if (!is_br) begin
            check_eq("ex_mem.result", ex_mem.result,
                     alu_model(p.op, p.pc, a, p.use_imm ? p.imm : b));
        end
        check_eq("dnpc", dnpc, exp_pc);
        check_eq("pc_update", pc_update, taken && ready_ex_mem);
    endtask

    // stage must stay blocked until the product appears
    task automatic wait_result(output int cycles);
        cycles = 0;
        while (!valid_ex_mem) begin
            check_eq("ready_id_ex", ready_id_ex, 1'b0);
            if (cycles >= MUL_TIMEOUT) begin
                fail_now("timeout waiting for the multiply result");
            end else begin
                step();
                cycles++;
            end
        end
    endtask

    task automatic reset_state();
        check_eq("valid_ex_mem", valid_ex_mem, 1'b0);
        check_eq("pc_update", pc_update, 1'b0);
        check_eq("ready_id_ex", ready_id_ex, ready_ex_mem);
        ready_ex_mem = 1'b0;
        #1;
        check_eq("ready_id_ex", ready_id_ex, 1'b0);
        ready_ex_mem = 1'b1;
        step();
    endtask

    task automatic alu_sweep();
        exu_pkg::id_ex_t p;
        clear_fwd();
        for (int i = 0; i < 10; i++) begin
            for (int f = 0; f < 2; f++) begin
                for (int n = 0; n < 4; n++) begin
                    p = make_pkt(alu_ops[i], f[0]);
                    issue(p);
                    check_exec(p);
                end
            end
        end
    endtask

    task automatic forwarding_priority();
        exu_pkg::id_ex_t p;
        p       = make_pkt(exu_pkg::OP_ADD, 1'b0);  // both stages hit rs1
        p.rs1   = 5'd5;
        p.rs2   = 5'd7;
        mem_fwd = make_fwd(1'b1, 5'd5);
        wb_fwd  = make_fwd(1'b1, 5'd5);
        issue(p);
        check_eq("ex_mem.result", ex_mem.result, mem_fwd.data + p.src_b);
        check_exec(p);
        p       = make_pkt(exu_pkg::OP_SUB, 1'b0);
        p.rs1   = 5'd5;
        p.rs2   = 5'd7;
        mem_fwd = make_fwd(1'b0, 5'd7);  // mem lacks wen so wb wins
        wb_fwd  = make_fwd(1'b1, 5'd7);
        issue(p);
        check_eq("ex_mem.store_data", ex_mem.store_data, wb_fwd.data);
        check_exec(p);
        p       = make_pkt(exu_pkg::OP_XOR, 1'b0);
        p.rs1   = 5'd0;
        p.rs2   = 5'd0;
        mem_fwd = make_fwd(1'b1, 5'd0);
        wb_fwd  = make_fwd(1'b1, 5'd0);
        issue(p);
        check_eq("ex_mem.result", ex_mem.result, p.src_a ^ p.src_b);
        check_exec(p);
        p       = make_pkt(exu_pkg::OP_OR, 1'b1);  // rs2 field unused
        p.rs1   = 5'd9;
        p.rs2   = 5'd9;
        mem_fwd = make_fwd(1'b1, 5'd9);
        wb_fwd  = make_fwd(1'b1, 5'd9);
        issue(p);
        check_eq("ex_mem.store_data", ex_mem.store_data, p.src_b);
        check_eq("ex_mem.result", ex_mem.result, mem_fwd.data | p.imm);
        check_exec(p);
        clear_fwd();
    endtask

    task automatic branch_sweep();
        exu_pkg::id_ex_t p;
        for (int i = 0; i < 8; i++) begin
            for (int n = 0; n < 6; n++) begin
                p = make_pkt(br_ops[i], 1'b0);
                if (n[0]) begin
                    p.src_b = p.src_a;
                end
                issue(p);
                check_exec(p);
            end
        end
        p = make_pkt(exu_pkg::OP_JAL, 1'b0);
        issue(p);
        ready_ex_mem = 1'b0;  // downstream stall holds back the redirect
        #1;
        check_exec(p);
        check_eq("ready_id_ex", ready_id_ex, 1'b0);
        ready_ex_mem = 1'b1;
        step();
    endtask

    task automatic multiply_stall();
        exu_pkg::id_ex_t p;
        int              n;
        for (int k = 0; k < 2; k++) begin
            p = make_pkt(exu_pkg::OP_MUL, 1'b0);  // second one issues back to back
            issue(p);
            check_eq("valid_ex_mem", valid_ex_mem, 1'b0);
            check_eq("ready_id_ex", ready_id_ex, 1'b0);
            wait_result(n);
            check_eq("mul latency", n, `EXU_MUL_CYCLES + 1);
            check_exec(p);
        end
        p = make_pkt(exu_pkg::OP_MUL, 1'b0);
        issue(p);
        ready_ex_mem = 1'b0;
        for (int i = 0; i < 5; i++) begin
            step();
            check_eq("valid_ex_mem", valid_ex_mem, 1'b0);
            check_eq("ready_id_ex", ready_id_ex, 1'b0);
        end
        ready_ex_mem = 1'b1;  // multiplier starts only now
        wait_result(n);
        check_eq("mul latency", n, `EXU_MUL_CYCLES + 1);
        ready_ex_mem = 1'b0;
        for (int i = 0; i < 3; i++) begin
            step();
            check_exec(p);  // product held in done
            check_eq("ready_id_ex", ready_id_ex, 1'b0);
        end
        ready_ex_mem = 1'b1;
        step();
        check_eq("valid_ex_mem", valid_ex_mem, 1'b0);
    endtask

    task automatic flush_recovery();
        exu_pkg::id_ex_t p;
        int              n;
        p = make_pkt(exu_pkg::OP_JAL, 1'b0);  // held taken jump
        issue(p);
        ready_ex_mem = 1'b0;
        step();
        check_exec(p);
        branch_flush = 1'b1;
        step();
        branch_flush = 1'b0;
        ready_ex_mem = 1'b1;  // stale jump must not redirect
        #1;
        check_eq("valid_ex_mem", valid_ex_mem, 1'b0);
        check_eq("pc_update", pc_update, 1'b0);
        p = make_pkt(exu_pkg::OP_MUL, 1'b0);
        issue(p);
        repeat (10) step();
        branch_flush = 1'b1;  // abort mid multiply
        step();
        branch_flush = 1'b0;
        check_eq("valid_ex_mem", valid_ex_mem, 1'b0);
        check_eq("ready_id_ex", ready_id_ex, 1'b1);
        p = make_pkt(exu_pkg::OP_MUL, 1'b0);
        issue(p);
        wait_result(n);
        check_eq("mul latency", n, `EXU_MUL_CYCLES + 1);
        check_exec(p);
        p = make_pkt(exu_pkg::OP_ADD, 1'b1);
        issue(p);
        check_exec(p);
        step();
    endtask

    initial begin
        void'($urandom(32'h870472ce));
        clk          = 1'b0;
        rst_n        = 1'b0;
        valid_id_ex  = 1'b0;
        id_ex        = '0;
        mem_fwd      = '0;
        wb_fwd       = '0;
        ready_ex_mem = 1'b1;
        branch_flush = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        alu_sweep();
        forwarding_priority();
        branch_sweep();
        multiply_stall();
        flush_recovery();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src/exu_stage.sv */
`default_nettype none

module exu_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    valid_id_ex,
    input  wire exu_pkg::id_ex_t   id_ex,
    input  wire exu_pkg::fwd_t     mem_fwd,
    input  wire exu_pkg::fwd_t     wb_fwd,
    input  wire                    ready_ex_mem,
    input  wire                    branch_flush,
    output logic                   ready_id_ex,
    output logic                   valid_ex_mem,
    output exu_pkg::ex_mem_t       ex_mem,
    output exu_pkg::xlen_t         dnpc,
    output logic                   pc_update
);

    exu_pkg::id_ex_t id_ex_q;
    logic            valid_q;
    exu_pkg::xlen_t  src1;
    exu_pkg::xlen_t  src2;
    exu_pkg::xlen_t  alu_result;
    exu_pkg::xlen_t  product;
    logic            uses_rs2;
    logic            is_mul;
    logic            mul_start;
    logic            mul_ack;
    logic            mul_done;
    logic            mul_block;

    // id/ex register, flush beats capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (branch_flush) begin
            valid_q <= 1'b0;
        end else if (ready_id_ex) begin
            valid_q <= valid_id_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_id_ex && !branch_flush) begin
            id_ex_q <= id_ex;
        end
    end

    // jumps and immediate forms do not read rs2
    assign uses_rs2 = !id_ex_q.use_imm
                    && (id_ex_q.op != exu_pkg::OP_JAL)
                    && (id_ex_q.op != exu_pkg::OP_JALR);

    assign is_mul    = valid_q && (id_ex_q.op == exu_pkg::OP_MUL);
    assign mul_block = is_mul && !mul_done;          // stall until product lands
    assign mul_start = is_mul && ready_ex_mem;
    assign mul_ack   = is_mul && mul_done && ready_ex_mem;

    assign ready_id_ex  = ready_ex_mem && !mul_block;
    assign valid_ex_mem = valid_q && !mul_block;

    exu_operand_fwd u_fwd (
        .rs1       (id_ex_q.rs1),
        .rs2       (id_ex_q.rs2),
        .reg_src_a (id_ex_q.src_a),
        .reg_src_b (id_ex_q.src_b),
        .uses_rs2  (uses_rs2),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .src1      (src1),
        .src2      (src2)
    );

    exu_alu u_alu (
        .op      (id_ex_q.op),
        .use_imm (id_ex_q.use_imm),
        .pc      (id_ex_q.pc),
        .src1    (src1),
        .src2    (src2),
        .imm     (id_ex_q.imm),
        .result  (alu_result)
    );

    exu_branch u_branch (
        .op           (id_ex_q.op),
        .valid        (valid_q),
        .ready_ex_mem (ready_ex_mem),
        .pc           (id_ex_q.pc),
        .src1         (src1),
        .src2         (src2),
        .imm          (id_ex_q.imm),
        .dnpc         (dnpc),
        .pc_update    (pc_update)
    );

    exu_mul u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mul_start),
        .ack          (mul_ack),
        .flush        (branch_flush),
        .multiplicand (src1),
        .multiplier   (src2),
        .done         (mul_done),
        .product      (product)
    );

    always_comb begin
        ex_mem.op         = id_ex_q.op;
        ex_mem.pc         = id_ex_q.pc;
        ex_mem.rd         = id_ex_q.rd;
        ex_mem.result     = is_mul ? product : alu_result;
        ex_mem.store_data = src2;  // forwarded value
    end

endmodule

`default_nettype wire

/* src/exu_mul.sv */
`include "exu_defs.svh"
`default_nettype none

module exu_mul (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start,
    input  wire                 ack,
    input  wire                 flush,
    input  wire exu_pkg::xlen_t multiplicand,
    input  wire exu_pkg::xlen_t multiplier,
    output logic                done,
    output exu_pkg::xlen_t      product
);

    localparam int CNT_W = $clog2(`EXU_MUL_CYCLES);

    exu_pkg::mul_state_e state_q;
    logic [CNT_W-1:0]    cnt_q;
    exu_pkg::xlen_t      mcand_q;   // shifts left each step
    exu_pkg::xlen_t      mplier_q;  // shifts right, lsb picks the add
    exu_pkg::xlen_t      acc_q;
    logic                last_iter;

    assign last_iter = (cnt_q == CNT_W'(`EXU_MUL_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= exu_pkg::IDLE;
            cnt_q   <= '0;
        end else if (flush) begin
            state_q <= exu_pkg::IDLE;  // abort, result dropped
            cnt_q   <= '0;
        end else begin
            case (state_q)
                exu_pkg::IDLE: begin
                    if (start) begin
                        state_q <= exu_pkg::BUSY;
                        cnt_q   <= '0;
                    end
                end
                exu_pkg::BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_iter) begin
                        state_q <= exu_pkg::DONE;
                    end
                end
                exu_pkg::DONE: begin
                    if (ack) begin
                        state_q <= exu_pkg::IDLE;
                    end
                end
                default: state_q <= exu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == exu_pkg::IDLE) && start) begin
            mcand_q  <= multiplicand;
            mplier_q <= multiplier;
            acc_q    <= '0;
        end else if (state_q == exu_pkg::BUSY) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;  // low half only
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign done    = (state_q == exu_pkg::DONE);
    assign product = acc_q;

endmodule

`default_nettype wire

/* src/exu_branch.sv */
`include "exu_defs.svh"
`default_nettype none

module exu_branch (
    input  wire exu_pkg::exu_op_e op,
    input  wire                   valid,
    input  wire                   ready_ex_mem,
    input  wire exu_pkg::xlen_t   pc,
    input  wire exu_pkg::xlen_t   src1,
    input  wire exu_pkg::xlen_t   src2,
    input  wire exu_pkg::xlen_t   imm,
    output exu_pkg::xlen_t        dnpc,
    output logic                  pc_update
);

    logic           taken;
    exu_pkg::xlen_t seq_pc;
    exu_pkg::xlen_t target;

    assign seq_pc = pc + exu_pkg::xlen_t'(`EXU_PC_STEP);
    assign target = (op == exu_pkg::OP_JALR) ? src1 + imm  // register relative
                                             : pc + imm;

    always_comb begin
        case (op)
            exu_pkg::OP_BEQ:  taken = (src1 == src2);
            exu_pkg::OP_BNE:  taken = (src1 != src2);
            exu_pkg::OP_BLT:  taken = $signed(src1) < $signed(src2);
            exu_pkg::OP_BGE:  taken = $signed(src1) >= $signed(src2);
            exu_pkg::OP_BLTU: taken = src1 < src2;
            exu_pkg::OP_BGEU: taken = src1 >= src2;
            exu_pkg::OP_JAL, exu_pkg::OP_JALR: begin
                taken = 1'b1;  // unconditional
            end
            default:          taken = 1'b0;
        endcase
    end

    assign dnpc = taken ? target : seq_pc;

    // redirect only once the instruction actually leaves
    assign pc_update = valid && ready_ex_mem && taken;

endmodule

`default_nettype wire

/* src/exu_alu.sv */
`include "exu_defs.svh"
`default_nettype none

module exu_alu (
    input  wire exu_pkg::exu_op_e op,
    input  wire                   use_imm,
    input  wire exu_pkg::xlen_t   pc,
    input  wire exu_pkg::xlen_t   src1,
    input  wire exu_pkg::xlen_t   src2,
    input  wire exu_pkg::xlen_t   imm,
    output exu_pkg::xlen_t        result
);

    exu_pkg::xlen_t          op_b;
    logic [`EXU_SHAMT_W-1:0] shamt;
    exu_pkg::xlen_t          sum;
    exu_pkg::xlen_t          diff;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign op_b  = use_imm ? imm : src2;
    assign shamt = op_b[`EXU_SHAMT_W-1:0];  // upper bits ignored
    assign sum   = src1 + op_b;
    assign diff  = src1 - op_b;

    assign lt_signed   = $signed(src1) < $signed(op_b);
    assign lt_unsigned = src1 < op_b;

    always_comb begin
        case (op)
            exu_pkg::OP_ADD: begin
                result = sum;
            end
            exu_pkg::OP_SUB: begin
                result = diff;
            end
            exu_pkg::OP_SLL: begin
                result = src1 << shamt;
            end
            exu_pkg::OP_SLT: begin
                result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
            end
            exu_pkg::OP_SLTU: begin
                result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
            end
            exu_pkg::OP_XOR: begin
                result = src1 ^ op_b;
            end
            exu_pkg::OP_SRL: begin
                result = src1 >> shamt;
            end
            exu_pkg::OP_SRA: begin
                result = exu_pkg::xlen_t'($signed(src1) >>> shamt);  // sign fill
            end
            exu_pkg::OP_OR: begin
                result = src1 | op_b;
            end
            exu_pkg::OP_AND: begin
                result = src1 & op_b;
            end
            // link value for jumps
            exu_pkg::OP_JAL, exu_pkg::OP_JALR: begin
                result = pc + exu_pkg::xlen_t'(`EXU_PC_STEP);
            end
            default: begin
                result = sum;  // branches and mul take no alu result
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/exu_operand_fwd.sv */
`default_nettype none

module exu_operand_fwd (
    input  wire exu_pkg::reg_addr_t rs1,
    input  wire exu_pkg::reg_addr_t rs2,
    input  wire exu_pkg::xlen_t     reg_src_a,
    input  wire exu_pkg::xlen_t     reg_src_b,
    input  wire                     uses_rs2,
    input  wire exu_pkg::fwd_t      mem_fwd,
    input  wire exu_pkg::fwd_t      wb_fwd,
    output exu_pkg::xlen_t          src1,
    output exu_pkg::xlen_t          src2
);

    // youngest writer wins, x0 never forwards
    function automatic exu_pkg::xlen_t select_src(
        input exu_pkg::reg_addr_t idx,
        input exu_pkg::xlen_t     reg_val,
        input exu_pkg::fwd_t      mem,
        input exu_pkg::fwd_t      wb
    );
        logic nonzero;
        nonzero = (idx != '0);
        if (nonzero && mem.wen && (mem.rd == idx)) begin
            return mem.data;
        end
        if (nonzero && wb.wen && (wb.rd == idx)) begin
            return wb.data;
        end
        return reg_val;
    endfunction

    assign src1 = select_src(rs1, reg_src_a, mem_fwd, wb_fwd);
    assign src2 = uses_rs2 ? select_src(rs2, reg_src_b, mem_fwd, wb_fwd)
                           : reg_src_b;  // rs2 field is not a source here

endmodule

`default_nettype wire

/* src/exu_pkg.sv */
`include "exu_defs.svh"
`default_nettype none

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]       xlen_t;
    typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,  // integer alu
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,
        OP_MUL                                    // iterative, holds the stage
    } exu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } mul_state_e;

    // packet from decode
    typedef struct packed {
        exu_op_e   op;
        logic      use_imm;   // operand b from imm
        xlen_t     pc;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     src_a;     // regfile read of rs1
        xlen_t     src_b;     // regfile read of rs2
        xlen_t     imm;
    } id_ex_t;

    typedef struct packed {
        exu_op_e   op;
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     result;
        xlen_t     store_data;
    } ex_mem_t;

    // a later stage that may write rd
    typedef struct packed {
        logic      wen;
        reg_addr_t rd;
        xlen_t     data;
    } fwd_t;

endpackage

`default_nettype wire

/* src/exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath and register file
`define EXU_XLEN        64
`define EXU_REG_ADDR_W  5

// byte step to the next sequential instruction
`define EXU_PC_STEP     4

// rv64 shifts use six bits of operand b
`define EXU_SHAMT_W     6

// one shift-add iteration per multiplier bit
`define EXU_MUL_CYCLES  64

`endif
